//--- logic/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// byte address width of the core
`define PC_WIDTH 32

// table index taken from pc[9:2]
`define INDEX_WIDTH 8

// entries in the direct-mapped target table
`define NR_SLOT 256

// max fetches waiting for their resolve
`define QUEUE_DEPTH 4

// boot vector
`define RESET_PC 32'hBFC0_0000

// word step between sequential fetches
`define PC_STEP 4

// low address bits always zero for aligned fetch
`define WORD_SHIFT 2

`endif

//--- logic/fetch_pkg.sv
`include "fetch_defs.svh"

package fetch_pkg;

    // full byte address as seen on the fetch ports
    typedef logic [`PC_WIDTH-1:0] pc_t;

    // address without the two zero low bits
    // the target table keeps only this part
    typedef logic [`PC_WIDTH-`WORD_SHIFT-1:0] word_pc_t;

    // slot number in the target table
    typedef logic [`INDEX_WIDTH-1:0] index_t;

    // pc[9:2] picks the slot
    function automatic index_t slot_of(input pc_t pc);
        return pc[`INDEX_WIDTH+`WORD_SHIFT-1:`WORD_SHIFT];
    endfunction

    // strip the byte offset before storing a target
    function automatic word_pc_t word_of(input pc_t pc);
        return pc[`PC_WIDTH-1:`WORD_SHIFT];
    endfunction

endpackage

//--- logic/branch_predictor.sv
`timescale 1ns/1ps

`include "fetch_defs.svh"

module branch_predictor (
    input  logic             clk,
    input  logic             reset,
    input  fetch_pkg::pc_t   lookup_pc,      // current fetch address
    input  fetch_pkg::pc_t   update_pc,      // oldest record selects the slot to train
    input  fetch_pkg::pc_t   update_next_pc, // resolved next address for update_pc
    input  logic             update_en,      // mispredict retrains the slot
    input  logic             strengthen_en,  // correct prediction sets the bit
    output fetch_pkg::pc_t   predicted_pc    // next fetch address
);

    import fetch_pkg::*;

    // per-slot state
    // valid is sticky once set
    // predict bit gives one mispredict of slack before the target moves
    logic [`NR_SLOT-1:0] slot_valid;
    logic [`NR_SLOT-1:0] slot_predict;
    word_pc_t            slot_target [`NR_SLOT]; // word target per slot

    index_t   lookup_idx;
    index_t   update_idx;
    logic     update_bit;   // current predict bit of the slot being trained
    word_pc_t update_word;  // target in table format

    assign lookup_idx  = slot_of(lookup_pc);
    assign update_idx  = slot_of(update_pc);
    assign update_bit  = slot_predict[update_idx];
    assign update_word = word_of(update_next_pc);

    // lookup is purely combinational
    // a write at the edge shows up in the next cycle's lookup
    always_comb begin
        if (slot_valid[lookup_idx]) begin
            predicted_pc = {slot_target[lookup_idx], {`WORD_SHIFT{1'b0}}};
        end else begin
            predicted_pc = lookup_pc + pc_t'(`PC_STEP); // sequential fall-through
        end
    end

    // valid and predict bits
    always_ff @(posedge clk) begin
        if (reset) begin
            slot_valid   <= '0;  // every entry invalid after reset
            slot_predict <= '0;
        end else if (update_en) begin
            slot_valid[update_idx]   <= 1'b1;
            // one bit so toggling is the same as counting
            slot_predict[update_idx] <= ~update_bit;
        end else if (strengthen_en) begin
            // only a slot that already holds a target gets reinforced
            if (slot_valid[update_idx]) begin
                slot_predict[update_idx] <= 1'b1;
            end
        end
    end

    // target storage
    // bit clear means no confidence yet so replace right away
    // bit set keeps the old target for one more try
    always_ff @(posedge clk) begin
        if (update_en && !reset) begin
            if (!update_bit) begin
                slot_target[update_idx] <= update_word;
            end
        end
    end

endmodule

//--- logic/prediction_queue.sv
`timescale 1ns/1ps

`include "fetch_defs.svh"

module prediction_queue #(
    parameter int DEPTH = `QUEUE_DEPTH  // power of two and at least 2
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            push,             // record the current fetch
    input  fetch_pkg::pc_t  push_pc,          // fetched address
    input  fetch_pkg::pc_t  push_next_pc,     // what was predicted after it
    input  logic            pop,              // head resolved as predicted
    input  logic            flush,            // drop everything on redirect
    input  fetch_pkg::pc_t  resolve_next_pc,  // true next address of the head
    output logic            full,
    output logic            empty,
    output fetch_pkg::pc_t  head_pc,          // oldest unresolved fetch
    output logic            mismatch          // head prediction was wrong
);

    import fetch_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    // record storage
    pc_t rec_pc   [DEPTH];
    pc_t rec_next [DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;     // one extra bit to tell full from empty

    logic do_push;
    logic do_pop;

    assign full  = (count == (PTR_W+1)'(DEPTH));
    assign empty = (count == '0);

    // a push in the flush cycle belongs to the wrong path
    assign do_push = push && !full && !flush;
    assign do_pop  = pop && !empty && !flush;

    assign head_pc = rec_pc[rd_ptr];

    // garbage when empty so the caller qualifies it with the resolve strobe
    assign mismatch = (rec_next[rd_ptr] != resolve_next_pc);

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;  // restart from slot 0 since old records are dead
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps for power of two depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    // record write at the tail
    always_ff @(posedge clk) begin
        if (do_push) begin
            rec_pc[wr_ptr]   <= push_pc;
            rec_next[wr_ptr] <= push_next_pc;
        end
    end

endmodule

//--- logic/fetch_control.sv
`timescale 1ns/1ps

`include "fetch_defs.svh"

module fetch_control (
    input  logic            clk,
    input  logic            reset,
    input  logic            fetch_stall,      // hold fetch this cycle
    input  logic            resolve_valid,    // one instruction resolved
    input  fetch_pkg::pc_t  resolve_next_pc,  // its true successor
    input  fetch_pkg::pc_t  predicted_pc,     // table answer for fetch_pc
    input  logic            full,             // queue cannot take a record
    input  logic            mismatch,         // head record disagrees with resolve
    output fetch_pkg::pc_t  fetch_pc,
    output logic            fetch_valid,
    output logic            push,
    output fetch_pkg::pc_t  push_pc,
    output fetch_pkg::pc_t  push_next_pc,
    output logic            pop,
    output logic            flush,
    output logic            update_en,
    output logic            strengthen_en,
    output logic            mispredict
);

    import fetch_pkg::*;

    pc_t  fetch_pc_next;
    logic fetch_enable;   // low for the first cycle out of reset
    logic redirect;

    // resolve outcome, one of two mutually exclusive paths
    assign mispredict    = resolve_valid && mismatch;
    assign redirect      = mispredict;
    assign pop           = resolve_valid && !mismatch;  // head was right
    assign flush         = redirect;      // younger records are wrong path
    assign update_en     = redirect;      // retrain head slot
    assign strengthen_en = pop;           // confirm head slot

    // fetch happens when nothing blocks it
    assign fetch_valid = fetch_enable && !fetch_stall && !full && !redirect;

    // record what was fetched and what we guessed comes next
    assign push         = fetch_valid;
    assign push_pc      = fetch_pc;
    assign push_next_pc = predicted_pc;

    // next fetch address, redirect wins over everything
    always_comb begin
        if (redirect) begin
            fetch_pc_next = resolve_next_pc;
        end else if (fetch_valid) begin
            fetch_pc_next = predicted_pc;  // follow the table
        end else begin
            fetch_pc_next = fetch_pc;      // stall or queue full
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc     <= `RESET_PC;
            fetch_enable <= 1'b0;
        end else begin
            fetch_pc     <= fetch_pc_next;
            fetch_enable <= 1'b1;
        end
    end

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/1ps

`include "fetch_defs.svh"

module fetch_unit (
    input  logic            clk,
    input  logic            reset,
    input  logic            fetch_stall,
    input  logic            resolve_valid,
    input  fetch_pkg::pc_t  resolve_next_pc,
    output fetch_pkg::pc_t  fetch_pc,
    output fetch_pkg::pc_t  predicted_pc,
    output logic            fetch_valid,
    output logic            mispredict
);

    import fetch_pkg::*;

    // queue side
    logic push;
    pc_t  push_pc;
    pc_t  push_next_pc;
    logic pop;
    logic flush;
    logic full;
    logic empty;       // queue holds no record
    pc_t  head_pc;
    logic mismatch;

    // table training
    logic update_en;
    logic strengthen_en;

    fetch_control u_fetch_control (
        .clk             (clk),
        .reset           (reset),
        .fetch_stall     (fetch_stall),
        .resolve_valid   (resolve_valid),
        .resolve_next_pc (resolve_next_pc),
        .predicted_pc    (predicted_pc),
        .full            (full),
        .mismatch        (mismatch),
        .fetch_pc        (fetch_pc),
        .fetch_valid     (fetch_valid),
        .push            (push),
        .push_pc         (push_pc),
        .push_next_pc    (push_next_pc),
        .pop             (pop),
        .flush           (flush),
        .update_en       (update_en),
        .strengthen_en   (strengthen_en),
        .mispredict      (mispredict)
    );

    branch_predictor u_branch_predictor (
        .clk            (clk),
        .reset          (reset),
        .lookup_pc      (fetch_pc),
        .update_pc      (head_pc),          // train the slot of the oldest fetch
        .update_next_pc (resolve_next_pc),
        .update_en      (update_en),
        .strengthen_en  (strengthen_en),
        .predicted_pc   (predicted_pc)
    );

    prediction_queue #(
        .DEPTH (`QUEUE_DEPTH)
    ) u_prediction_queue (
        .clk             (clk),
        .reset           (reset),
        .push            (push),
        .push_pc         (push_pc),
        .push_next_pc    (push_next_pc),
        .pop             (pop),
        .flush           (flush),
        .resolve_next_pc (resolve_next_pc),
        .full            (full),
        .empty           (empty),
        .head_pc         (head_pc),
        .mismatch        (mismatch)
    );

endmodule

//--- sim/fetch_unit_checker.sv
`timescale 1ns/1ps

module fetch_unit_checker (
    input logic clk,
    input logic reset,
    input logic resolve_valid,
    input logic mispredict,
    input logic fetch_valid,
    input logic empty    // queue occupancy inside fetch_unit
);

    // a resolve always refers to the oldest record
    property resolve_needs_record;
        @(posedge clk) disable iff (reset) resolve_valid |-> !empty;
    endproperty

    property mispredict_needs_resolve;
        @(posedge clk) disable iff (reset) mispredict |-> resolve_valid;
    endproperty

    // one reset edge clears the fetch enable
    property quiet_in_reset;
        @(posedge clk) $past(reset) |-> !fetch_valid;
    endproperty

    a_resolve_needs_record: assert property (resolve_needs_record)
        else $error("resolve strobe while the prediction queue is empty");

    a_mispredict_needs_resolve: assert property (mispredict_needs_resolve)
        else $error("mispredict raised without a resolve strobe");

    a_quiet_in_reset: assert property (quiet_in_reset)
        else $error("fetch_valid high during reset");

endmodule

bind fetch_unit fetch_unit_checker u_fetch_unit_checker (
    .clk           (clk),
    .reset         (reset),
    .resolve_valid (resolve_valid),
    .mispredict    (mispredict),
    .fetch_valid   (fetch_valid),
    .empty         (empty)
);

//--- sim/fetch_unit_monitor.sv
`timescale 1ns/1ps

`include "fetch_defs.svh"

module fetch_unit_monitor (
    input  logic           clk,
    input  logic           reset,
    input  logic           fetch_stall,
    input  logic           resolve_valid,
    input  fetch_pkg::pc_t resolve_next_pc,
    input  fetch_pkg::pc_t fetch_pc,
    input  fetch_pkg::pc_t predicted_pc,
    input  logic           fetch_valid,
    input  logic           mispredict,
    output int             check_count,
    output int             error_count
);

    import fetch_pkg::*;

    // reference table, full byte targets
    logic tbl_valid  [`NR_SLOT];
    logic tbl_bit    [`NR_SLOT];
    pc_t  tbl_target [`NR_SLOT];

    pc_t  rec_pc[$];    // oldest unresolved fetch first
    pc_t  rec_next[$];  // what was predicted after it
    pc_t  exp_pc;       // expected fetch address
    logic running;      // first cycle out of reset fetches nothing
    int   checks = 0;
    int   errors = 0;

    assign check_count = checks;
    assign error_count = errors;

    // slot comes from pc[9:2]
    function automatic int slot(input pc_t pc);
        return int'(pc[9:2]);
    endfunction

    task automatic compare(input string name, input pc_t got, input pc_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %0h expected %0h at %0t", name, got, exp, $time);
        end
    endtask

    // mid-cycle, all inputs and outputs settled
    always @(negedge clk) begin
        pc_t  exp_pred;
        logic exp_mis;
        logic exp_fv;
        int   idx;
        if (reset) begin
            for (int i = 0; i < `NR_SLOT; i++) begin
                tbl_valid[i] = 1'b0;
                tbl_bit[i]   = 1'b0;
            end
            rec_pc.delete();
            rec_next.delete();
            exp_pc  = `RESET_PC;
            running = 1'b0;
        end else begin
            idx      = slot(exp_pc);
            exp_pred = tbl_valid[idx] ? tbl_target[idx] : exp_pc + 32'd4;
            exp_mis  = 1'b0;
            if (resolve_valid) begin
                if (rec_pc.size() == 0) begin
                    errors++;
                    $display("resolve arrived with no fetch outstanding at %0t", $time);
                end else begin
                    exp_mis = (rec_next[0] != resolve_next_pc);
                end
            end
            exp_fv = running && !fetch_stall && (rec_pc.size() < `QUEUE_DEPTH) && !exp_mis;

            compare("fetch_pc", fetch_pc, exp_pc);
            compare("predicted_pc", predicted_pc, exp_pred);
            compare("fetch_valid", pc_t'(fetch_valid), pc_t'(exp_fv));
            compare("mispredict", pc_t'(mispredict), pc_t'(exp_mis));

            // state after the coming edge
            if (exp_mis) begin
                idx = slot(rec_pc[0]);
                if (!tbl_bit[idx]) begin
                    tbl_target[idx] = {resolve_next_pc[31:2], 2'b00}; // no confidence yet
                end
                tbl_bit[idx]   = !tbl_bit[idx];
                tbl_valid[idx] = 1'b1;
                rec_pc.delete();   // younger records were wrong path
                rec_next.delete();
                exp_pc = resolve_next_pc;
            end else begin
                if (resolve_valid && rec_pc.size() != 0) begin
                    idx = slot(rec_pc[0]);
                    if (tbl_valid[idx]) begin
                        tbl_bit[idx] = 1'b1;
                    end
                    void'(rec_pc.pop_front());
                    void'(rec_next.pop_front());
                end
                if (exp_fv) begin
                    rec_pc.push_back(exp_pc);
                    rec_next.push_back(exp_pred);
                    exp_pc = exp_pred;
                end
            end
            running = 1'b1;
        end
    end

endmodule

//--- sim/fetch_unit_tb.sv
`timescale 1ns/1ps

`include "fetch_defs.svh"

module fetch_unit_tb;

    import fetch_pkg::*;

    localparam int SEED          = 2118;
    localparam int RANDOM_CYCLES = 3000;
    localparam int WAIT_LIMIT    = 40;   // cycles before a wait gives up

    logic clk = 1'b0;
    logic reset;
    logic fetch_stall;
    logic resolve_valid;
    pc_t  resolve_next_pc;
    pc_t  fetch_pc;
    pc_t  predicted_pc;
    logic fetch_valid;
    logic mispredict;
    int   check_count;
    int   error_count;

    pc_t  outstanding[$];  // fetched addresses still waiting for a resolve
    pc_t  targets [4];     // small jump set so slots retrain
    int   test_num      = 0;
    int   tests_failed  = 0;
    int   errors_before = 0;
    int   checks_before = 0;
    logic hung          = 1'b0;

    always #4 clk = ~clk;  // 8 ns period

    fetch_unit u_fetch_unit (
        .clk             (clk),
        .reset           (reset),
        .fetch_stall     (fetch_stall),
        .resolve_valid   (resolve_valid),
        .resolve_next_pc (resolve_next_pc),
        .fetch_pc        (fetch_pc),
        .predicted_pc    (predicted_pc),
        .fetch_valid     (fetch_valid),
        .mispredict      (mispredict)
    );

    fetch_unit_monitor u_fetch_unit_monitor (
        .clk             (clk),
        .reset           (reset),
        .fetch_stall     (fetch_stall),
        .resolve_valid   (resolve_valid),
        .resolve_next_pc (resolve_next_pc),
        .fetch_pc        (fetch_pc),
        .predicted_pc    (predicted_pc),
        .fetch_valid     (fetch_valid),
        .mispredict      (mispredict),
        .check_count     (check_count),
        .error_count     (error_count)
    );

    task automatic reset_dut();
        reset           = 1'b1;
        fetch_stall     = 1'b0;
        resolve_valid   = 1'b0;
        resolve_next_pc = '0;
        outstanding.delete();
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    // drive one cycle, then follow what the queue now holds
    task automatic drive_cycle(input logic stall, input logic rv, input pc_t rnext);
        @(posedge clk);
        #1;
        fetch_stall     = stall;
        resolve_valid   = rv;
        resolve_next_pc = rnext;
        @(negedge clk);
        if (mispredict) begin
            outstanding.delete();  // flushed
        end else begin
            if (rv) begin
                void'(outstanding.pop_front());
            end
            if (fetch_valid) begin
                outstanding.push_back(fetch_pc);
            end
        end
    endtask

    // head plus four while near the base, else a jump
    function automatic pc_t pick_next_pc();
        pc_t head;
        head = outstanding[0];
        if (($urandom % 2 == 0) && (head[9:0] < 10'h180)) begin
            return head + 32'd4;
        end
        return targets[$urandom % 4];
    endfunction

    task automatic fetch_once();
        int waited;
        waited = 0;
        while (outstanding.size() == 0 && !hung) begin
            if (waited >= WAIT_LIMIT) begin
                $display("timeout: no fetch happened within %0d cycles", WAIT_LIMIT);
                hung = 1'b1;
            end else begin
                drive_cycle(1'b0, 1'b0, '0);
                waited++;
            end
        end
    endtask

    task automatic drain_queue();
        int waited;
        waited = 0;
        while (outstanding.size() != 0 && !hung) begin
            if (waited >= WAIT_LIMIT) begin
                $display("timeout: queue did not empty within %0d cycles", WAIT_LIMIT);
                hung = 1'b1;
            end else begin
                drive_cycle(1'b1, 1'b1, pick_next_pc());
                waited++;
            end
        end
    endtask

    task automatic random_traffic();
        logic rv;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            rv = (outstanding.size() != 0) && ($urandom % 3 == 0);
            drive_cycle(($urandom % 5) == 0, rv, rv ? pick_next_pc() : pc_t'(0));
        end
        drain_queue();
    endtask

    // slot 0 trained through both hysteresis states, one fetch at a time
    task automatic train_slot();
        int unsigned offsets [11];
        offsets = '{32'h40, 0, 32'h80, 0, 32'h40, 0, 32'h80, 0, 32'h80, 0, 32'h80};
        foreach (offsets[i]) begin
            fetch_once();
            if (!hung) begin
                drive_cycle(1'b1, 1'b1, pc_t'(`RESET_PC) + offsets[i]);
            end
        end
    endtask

    task automatic fill_queue();
        for (int i = 0; i < `QUEUE_DEPTH + 4; i++) begin
            drive_cycle(1'b0, 1'b0, '0);  // runs into full
        end
        for (int i = 0; i < 4; i++) begin
            drive_cycle(1'b1, 1'b0, '0);
        end
        drain_queue();
    endtask

    task automatic close_test(input string name);
        int new_errors;
        new_errors = error_count - errors_before;
        test_num++;
        if (new_errors != 0 || hung) begin
            tests_failed++;
        end
        $display("test %0d %-14s %s  checks %0d  errors %0d", test_num, name,
                 (new_errors == 0 && !hung) ? "ok" : "FAILED",
                 check_count - checks_before, new_errors);
        errors_before = error_count;
        checks_before = check_count;
    endtask

    initial begin
        void'($urandom(SEED));
        targets[0] = `RESET_PC;
        targets[1] = `RESET_PC + 32'h40;
        targets[2] = `RESET_PC + 32'h100;
        targets[3] = `RESET_PC + 32'h404;  // shares slot 1 with RESET_PC + 4
        reset_dut();
        drive_cycle(1'b1, 1'b0, '0);
        drive_cycle(1'b1, 1'b0, '0);
        close_test("reset");
        random_traffic();
        close_test("random");
        @(posedge clk);
        #1;
        reset_dut();
        train_slot();
        close_test("hysteresis");
        fill_queue();
        close_test("back-pressure");
        $display("tests %0d  failed %0d  checks %0d  errors %0d",
                 test_num, tests_failed, check_count, error_count);
        if (hung || tests_failed != 0 || error_count != 0) begin
            $display("Simulation failed");
        end else begin
            $display("Simulation completed successfully");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+logic
logic/fetch_pkg.sv
logic/branch_predictor.sv
logic/prediction_queue.sv
logic/fetch_control.sv
logic/fetch_unit.sv
sim/fetch_unit_checker.sv
sim/fetch_unit_monitor.sv
sim/fetch_unit_tb.sv

//--- Makefile
TOP := fetch_unit_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Simulation failed" sim.log; then \
		echo "sim FAIL"; exit 1; \
	elif ! grep -q "Simulation completed successfully" sim.log; then \
		echo "sim FAIL, run ended early"; exit 1; \
	else \
		echo "sim PASS"; \
	fi

clean:
	rm -rf obj_dir sim.log
